/* rtl/bbox_defines.svh */
// Shared widths for the bounding-box stage; coordinates are two's complement with RADIX fraction bits
`ifndef BBOX_DEFINES_SVH
`define BBOX_DEFINES_SVH

// Total bits in one coordinate
`define BBOX_SIGFIG 24

// Fraction bits at the bottom of a coordinate
// Must be at least 3 for the 64x grid
`define BBOX_RADIX 10

// Vertices per triangle
`define BBOX_VERTS 3

// Axes per vertex, x then y
`define BBOX_AXES 2

// Register stages between input and output
`define BBOX_DEPTH 3

`endif

/* rtl/geometry_pkg.sv */
// Coordinate and cull arithmetic types; the cross product is kept at full width so it never wraps
`include "bbox_defines.svh"

package geometry_pkg;

    // Signed fixed point coordinate
    // Low RADIX bits hold the fraction
    typedef logic signed [`BBOX_SIGFIG-1:0] coord_t;

    // Difference of two coordinates
    // One extra bit so the subtraction cannot overflow
    typedef logic signed [`BBOX_SIGFIG:0] diff_t;

    // Product of two differences, 50 bits for 24-bit coordinates
    typedef logic signed [2*(`BBOX_SIGFIG+1)-1:0] cross_t;

endpackage

/* rtl/sampling_pkg.sv */
// Multisample codes are one-hot; any code outside the four listed below is handled as 1x
`include "bbox_defines.svh"

package sampling_pkg;

    // One-hot multisample selector
    typedef logic [3:0] sample_code_t;

    // Mask over the fraction bits of a coordinate
    // A set bit survives the floor to the sample grid
    typedef logic [`BBOX_RADIX-1:0] grid_mask_t;

    // One sample per pixel
    localparam sample_code_t SAMPLE_1X  = 4'b1000;
    // Half-pixel grid
    localparam sample_code_t SAMPLE_4X  = 4'b0100;
    // Quarter-pixel grid
    localparam sample_code_t SAMPLE_16X = 4'b0010;
    // Eighth-pixel grid
    localparam sample_code_t SAMPLE_64X = 4'b0001;

    // Grid masks that go with each code
    // 1x keeps no fraction bits at all
    localparam grid_mask_t MASK_1X  = '0;
    localparam grid_mask_t MASK_4X  = {1'b1, {(`BBOX_RADIX-1){1'b0}}};
    localparam grid_mask_t MASK_16X = {2'b11, {(`BBOX_RADIX-2){1'b0}}};
    localparam grid_mask_t MASK_64X = {3'b111, {(`BBOX_RADIX-3){1'b0}}};

endpackage

/* rtl/tri_input_stage.sv */
// First pipeline register; halt freezes it and the source must hold its inputs while halt is high
`timescale 1ns/1ps
`include "bbox_defines.svh"

module tri_input_stage
    import geometry_pkg::*;
    import sampling_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         halt,
    input  logic         tri_valid,
    input  sample_code_t subsample,
    input  coord_t       v0_x,
    input  coord_t       v0_y,
    input  coord_t       v1_x,
    input  coord_t       v1_y,
    input  coord_t       v2_x,
    input  coord_t       v2_y,
    input  coord_t       screen_w,
    input  coord_t       screen_h,
    // Vertices grouped by axis, then by vertex
    output coord_t       s1_coord [`BBOX_AXES-1:0][`BBOX_VERTS-1:0],
    // Screen size per axis
    output coord_t       s1_limit [`BBOX_AXES-1:0],
    output grid_mask_t   s1_mask,
    output logic         s1_valid
);

    grid_mask_t mask_in;

    // Sample code to fraction mask
    always_comb begin
        case (subsample)
            SAMPLE_4X:  mask_in = MASK_4X;
            SAMPLE_16X: mask_in = MASK_16X;
            SAMPLE_64X: mask_in = MASK_64X;
            // 1x and every illegal code
            default:    mask_in = MASK_1X;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_coord <= '{default: '0};
            s1_limit <= '{default: '0};
            s1_mask  <= MASK_1X;
            s1_valid <= 1'b0;
        end else if (!halt) begin
            // x axis lane input
            s1_coord[0][0] <= v0_x;
            s1_coord[0][1] <= v1_x;
            s1_coord[0][2] <= v2_x;
            // y axis lane input
            s1_coord[1][0] <= v0_y;
            s1_coord[1][1] <= v1_y;
            s1_coord[1][2] <= v2_y;
            // Width bounds x, height bounds y
            s1_limit[0]    <= screen_w;
            s1_limit[1]    <= screen_h;
            s1_mask        <= mask_in;
            s1_valid       <= tri_valid;
        end
    end

endmodule

/* rtl/axis_bound_lane.sv */
// One axis of the box; lo is clamped at zero and hi at limit, which is assumed non-negative
`timescale 1ns/1ps
`include "bbox_defines.svh"

module axis_bound_lane
    import geometry_pkg::*;
    import sampling_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       halt,
    // Same axis of all three vertices
    input  coord_t     c0,
    input  coord_t     c1,
    input  coord_t     c2,
    input  grid_mask_t mask,
    // Screen extent on this axis
    input  coord_t     limit,
    output coord_t     lo,
    output coord_t     hi,
    output logic       off_screen
);

    coord_t min_c;
    coord_t max_c;
    coord_t floor_lo;
    coord_t floor_hi;
    coord_t clamp_lo;
    coord_t clamp_hi;
    logic   off_now;

    // Smallest and largest of the three
    always_comb begin
        min_c = c0;
        if (c1 < min_c) begin
            min_c = c1;
        end
        if (c2 < min_c) begin
            min_c = c2;
        end
        max_c = c0;
        if (c1 > max_c) begin
            max_c = c1;
        end
        if (c2 > max_c) begin
            max_c = c2;
        end
    end

    // Floor to the sample grid
    // Integer part untouched, fraction ANDed with the mask
    // Rounds toward minus infinity for negative values too
    always_comb begin
        floor_lo = {min_c[`BBOX_SIGFIG-1:`BBOX_RADIX], min_c[`BBOX_RADIX-1:0] & mask};
        floor_hi = {max_c[`BBOX_SIGFIG-1:`BBOX_RADIX], max_c[`BBOX_RADIX-1:0] & mask};
    end

    // Clamp to the screen
    always_comb begin
        if (floor_lo < 0) begin
            clamp_lo = '0;
        end else begin
            clamp_lo = floor_lo;
        end
        if (floor_hi > limit) begin
            clamp_hi = limit;
        end else begin
            clamp_hi = floor_hi;
        end
    end

    // Off screen test uses the unclamped corners
    // Whole span left of zero or right of the limit
    assign off_now = (floor_hi < 0) || (floor_lo > limit);

    // Stage 2 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lo         <= '0;
            hi         <= '0;
            off_screen <= 1'b0;
        end else if (!halt) begin
            lo         <= clamp_lo;
            hi         <= clamp_hi;
            off_screen <= off_now;
        end
    end

endmodule

/* rtl/cull_output_stage.sv */
// Stage 2 vertex copy and output register; counter-clockwise in screen space survives the cull
`timescale 1ns/1ps
`include "bbox_defines.svh"

module cull_output_stage
    import geometry_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   halt,
    // Stage 1 vertices, axis then vertex
    input  coord_t s1_coord [`BBOX_AXES-1:0][`BBOX_VERTS-1:0],
    input  logic   s1_valid,
    // Stage 2 box from the lanes
    input  coord_t lo_x,
    input  coord_t hi_x,
    input  coord_t lo_y,
    input  coord_t hi_y,
    input  logic   off_x,
    input  logic   off_y,
    output coord_t out_v0_x,
    output coord_t out_v0_y,
    output coord_t out_v1_x,
    output coord_t out_v1_y,
    output coord_t out_v2_x,
    output coord_t out_v2_y,
    output coord_t box_ll_x,
    output coord_t box_ll_y,
    output coord_t box_ur_x,
    output coord_t box_ur_y,
    output logic   box_valid
);

    coord_t s2_coord [`BBOX_AXES-1:0][`BBOX_VERTS-1:0];
    logic   s2_valid;
    diff_t  dx10;
    diff_t  dy21;
    diff_t  dx21;
    diff_t  dy10;
    cross_t cross_l;
    cross_t cross_r;
    logic   back_facing;

    // Stage 2 vertices, aligned with the lane registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_coord <= '{default: '0};
            s2_valid <= 1'b0;
        end else if (!halt) begin
            s2_coord <= s1_coord;
            s2_valid <= s1_valid;
        end
    end

    // Edge differences, sign extended by one bit
    always_comb begin
        dx10 = diff_t'(s2_coord[0][1]) - diff_t'(s2_coord[0][0]);
        dy21 = diff_t'(s2_coord[1][2]) - diff_t'(s2_coord[1][1]);
        dx21 = diff_t'(s2_coord[0][2]) - diff_t'(s2_coord[0][1]);
        dy10 = diff_t'(s2_coord[1][1]) - diff_t'(s2_coord[1][0]);
    end

    // Cross product terms at full width
    assign cross_l = cross_t'(dx10) * cross_t'(dy21);
    assign cross_r = cross_t'(dx21) * cross_t'(dy10);

    // Clockwise winding means the triangle faces away
    assign back_facing = cross_l > cross_r;

    // Stage 3 output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_v0_x  <= '0;
            out_v0_y  <= '0;
            out_v1_x  <= '0;
            out_v1_y  <= '0;
            out_v2_x  <= '0;
            out_v2_y  <= '0;
            box_ll_x  <= '0;
            box_ll_y  <= '0;
            box_ur_x  <= '0;
            box_ur_y  <= '0;
            box_valid <= 1'b0;
        end else if (!halt) begin
            out_v0_x  <= s2_coord[0][0];
            out_v0_y  <= s2_coord[1][0];
            out_v1_x  <= s2_coord[0][1];
            out_v1_y  <= s2_coord[1][1];
            out_v2_x  <= s2_coord[0][2];
            out_v2_y  <= s2_coord[1][2];
            box_ll_x  <= lo_x;
            box_ll_y  <= lo_y;
            box_ur_x  <= hi_x;
            box_ur_y  <= hi_y;
            // Drop invalid, off screen and back-facing triangles
            box_valid <= s2_valid && !off_x && !off_y && !back_facing;
        end
    end

endmodule

/* rtl/bbox_top.sv */
// Bounding-box stage top; three cycles of latency, and halt stalls all stages together
`timescale 1ns/1ps
`include "bbox_defines.svh"

module bbox_top
    import geometry_pkg::*;
    import sampling_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  coord_t       v0_x,
    input  coord_t       v0_y,
    input  coord_t       v1_x,
    input  coord_t       v1_y,
    input  coord_t       v2_x,
    input  coord_t       v2_y,
    input  logic         tri_valid,
    // Configuration, held steady while triangles are in flight
    input  coord_t       screen_w,
    input  coord_t       screen_h,
    input  sample_code_t subsample,
    // Stall from the next stage
    input  logic         halt,
    output coord_t       out_v0_x,
    output coord_t       out_v0_y,
    output coord_t       out_v1_x,
    output coord_t       out_v1_y,
    output coord_t       out_v2_x,
    output coord_t       out_v2_y,
    output coord_t       box_ll_x,
    output coord_t       box_ll_y,
    output coord_t       box_ur_x,
    output coord_t       box_ur_y,
    output logic         box_valid
);

    // Stage 1 wires
    coord_t     s1_coord [`BBOX_AXES-1:0][`BBOX_VERTS-1:0];
    coord_t     s1_limit [`BBOX_AXES-1:0];
    grid_mask_t s1_mask;
    logic       s1_valid;

    // Stage 2 lane results, index 0 is x
    coord_t     lane_lo  [`BBOX_AXES-1:0];
    coord_t     lane_hi  [`BBOX_AXES-1:0];
    logic       lane_off [`BBOX_AXES-1:0];

    tri_input_stage feed0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .tri_valid (tri_valid),
        .subsample (subsample),
        .v0_x      (v0_x),
        .v0_y      (v0_y),
        .v1_x      (v1_x),
        .v1_y      (v1_y),
        .v2_x      (v2_x),
        .v2_y      (v2_y),
        .screen_w  (screen_w),
        .screen_h  (screen_h),
        .s1_coord  (s1_coord),
        .s1_limit  (s1_limit),
        .s1_mask   (s1_mask),
        .s1_valid  (s1_valid)
    );

    // One lane per axis
    for (genvar a = 0; a < `BBOX_AXES; a++) begin : lane
        axis_bound_lane bound0 (
            .clk        (clk),
            .rst_n      (rst_n),
            .halt       (halt),
            .c0         (s1_coord[a][0]),
            .c1         (s1_coord[a][1]),
            .c2         (s1_coord[a][2]),
            .mask       (s1_mask),
            .limit      (s1_limit[a]),
            .lo         (lane_lo[a]),
            .hi         (lane_hi[a]),
            .off_screen (lane_off[a])
        );
    end

    cull_output_stage drain0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .s1_coord  (s1_coord),
        .s1_valid  (s1_valid),
        .lo_x      (lane_lo[0]),
        .hi_x      (lane_hi[0]),
        .lo_y      (lane_lo[1]),
        .hi_y      (lane_hi[1]),
        .off_x     (lane_off[0]),
        .off_y     (lane_off[1]),
        .out_v0_x  (out_v0_x),
        .out_v0_y  (out_v0_y),
        .out_v1_x  (out_v1_x),
        .out_v1_y  (out_v1_y),
        .out_v2_x  (out_v2_x),
        .out_v2_y  (out_v2_y),
        .box_ll_x  (box_ll_x),
        .box_ll_y  (box_ll_y),
        .box_ur_x  (box_ur_x),
        .box_ur_y  (box_ur_y),
        .box_valid (box_valid)
    );

endmodule

/* testbench/bbox_model.svh */
// Reference model of the box stage; screen sizes must be whole pixels and stay fixed during a run
`ifndef BBOX_MODEL_SVH
`define BBOX_MODEL_SVH

// Three slots, 0 is newest and 2 is what the outputs should show
// Vertex order in a slot is v0_x, v0_y, v1_x, v1_y, v2_x, v2_y
coord_t pipe_v     [3][6];
// Box order is ll_x, ll_y, ur_x, ur_y
coord_t pipe_box   [3][4];
logic   pipe_valid [3];
int     pipe_keep  [3];
int     culled;
int     rejected;

// Fraction bits kept by each one-hot code
function automatic int keep_bits(input logic [3:0] code);
    case (code)
        4'b0100: return 1;
        4'b0010: return 2;
        4'b0001: return 3;
        // 1x, and anything that is not one of the four codes
        default: return 0;
    endcase
endfunction

// Round down to a multiple of the grid step, toward minus infinity
function automatic longint grid_floor(input longint c, input int keep);
    longint step;
    longint r;
    step = longint'(1) << (`BBOX_RADIX - keep);
    r = c % step;
    if (r < 0) begin
        r = r + step;
    end
    return c - r;
endfunction

task automatic model_reset();
    for (int s = 0; s < 3; s++) begin
        for (int k = 0; k < 6; k++) begin
            pipe_v[s][k] = '0;
        end
        for (int k = 0; k < 4; k++) begin
            pipe_box[s][k] = '0;
        end
        pipe_valid[s] = 1'b0;
        pipe_keep[s]  = 0;
    end
endtask

// One rising edge of the model, halt holds every slot
task automatic model_clock();
    longint xs [3];
    longint ys [3];
    longint lo_x;
    longint hi_x;
    longint lo_y;
    longint hi_y;
    longint w;
    longint h;
    int     keep;
    logic   off;
    logic   back;
    if (!rst_n) begin
        model_reset();
    end else if (!halt) begin
        for (int s = 2; s > 0; s--) begin
            pipe_v[s]     = pipe_v[s-1];
            pipe_box[s]   = pipe_box[s-1];
            pipe_valid[s] = pipe_valid[s-1];
            pipe_keep[s]  = pipe_keep[s-1];
        end
        xs[0] = v0_x;
        xs[1] = v1_x;
        xs[2] = v2_x;
        ys[0] = v0_y;
        ys[1] = v1_y;
        ys[2] = v2_y;
        w = screen_w;
        h = screen_h;
        keep = keep_bits(subsample);
        lo_x = xs[0];
        hi_x = xs[0];
        lo_y = ys[0];
        hi_y = ys[0];
        for (int k = 1; k < 3; k++) begin
            lo_x = (xs[k] < lo_x) ? xs[k] : lo_x;
            hi_x = (xs[k] > hi_x) ? xs[k] : hi_x;
            lo_y = (ys[k] < lo_y) ? ys[k] : lo_y;
            hi_y = (ys[k] > hi_y) ? ys[k] : hi_y;
        end
        lo_x = grid_floor(lo_x, keep);
        hi_x = grid_floor(hi_x, keep);
        lo_y = grid_floor(lo_y, keep);
        hi_y = grid_floor(hi_y, keep);
        // Rejected when the floored box misses the screen on either axis
        off = (hi_x < 0) || (lo_x > w) || (hi_y < 0) || (lo_y > h);
        back = (xs[1] - xs[0]) * (ys[2] - ys[1]) > (xs[2] - xs[1]) * (ys[1] - ys[0]);
        pipe_v[0][0] = v0_x;
        pipe_v[0][1] = v0_y;
        pipe_v[0][2] = v1_x;
        pipe_v[0][3] = v1_y;
        pipe_v[0][4] = v2_x;
        pipe_v[0][5] = v2_y;
        pipe_box[0][0] = coord_t'((lo_x < 0) ? 0 : lo_x);
        pipe_box[0][1] = coord_t'((lo_y < 0) ? 0 : lo_y);
        pipe_box[0][2] = coord_t'((hi_x > w) ? w : hi_x);
        pipe_box[0][3] = coord_t'((hi_y > h) ? h : hi_y);
        pipe_valid[0]  = tri_valid && !off && !back;
        pipe_keep[0]   = keep;
        if (tri_valid && off) begin
            rejected++;
        end
        if (tri_valid && !off && back) begin
            culled++;
        end
    end
endtask

`endif

/* testbench/bbox_tb.sv */
// Random testbench for bbox_top; screen size is set once before reset and held for the whole run
`timescale 1ns/1ps
`include "bbox_defines.svh"

module bbox_tb
    import geometry_pkg::*;
    import sampling_pkg::*;
();

    localparam int NUM_TRI   = 1000;
    localparam int MAX_CYCLE = NUM_TRI * 2 + 50;

    logic         clk;
    logic         rst_n;
    logic         halt;
    logic         tri_valid;
    logic [3:0]   subsample;
    coord_t       v0_x;
    coord_t       v0_y;
    coord_t       v1_x;
    coord_t       v1_y;
    coord_t       v2_x;
    coord_t       v2_y;
    coord_t       screen_w;
    coord_t       screen_h;
    coord_t       out_v0_x;
    coord_t       out_v0_y;
    coord_t       out_v1_x;
    coord_t       out_v1_y;
    coord_t       out_v2_x;
    coord_t       out_v2_y;
    coord_t       box_ll_x;
    coord_t       box_ll_y;
    coord_t       box_ur_x;
    coord_t       box_ur_y;
    logic         box_valid;

    integer       seed;
    int           errors;
    int           checks;
    int           sent;
    int           cycles;
    logic         taken;
    logic         held_edge;
    logic         pair_pending;
    logic [240:0] last_out;
    // Four legal codes, then one illegal code that should act as 1x
    logic [3:0]   sample_codes [5] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001, 4'b1010};

    `include "bbox_model.svh"

    bbox_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .v0_x      (v0_x),
        .v0_y      (v0_y),
        .v1_x      (v1_x),
        .v1_y      (v1_y),
        .v2_x      (v2_x),
        .v2_y      (v2_y),
        .tri_valid (tri_valid),
        .screen_w  (screen_w),
        .screen_h  (screen_h),
        .subsample (subsample),
        .halt      (halt),
        .out_v0_x  (out_v0_x),
        .out_v0_y  (out_v0_y),
        .out_v1_x  (out_v1_x),
        .out_v1_y  (out_v1_y),
        .out_v2_x  (out_v2_x),
        .out_v2_y  (out_v2_y),
        .box_ll_x  (box_ll_x),
        .box_ll_y  (box_ll_y),
        .box_ur_x  (box_ur_x),
        .box_ur_y  (box_ur_y),
        .box_valid (box_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    // Anywhere from a quarter screen before zero to a quarter past the edge
    function automatic coord_t span_coord(input coord_t limit);
        longint l;
        l = limit;
        return coord_t'(longint'(rand_below(int'(l + l / 2))) - l / 4);
    endfunction

    // Center of a small triangle, often fully off screen
    function automatic longint center_coord(input coord_t limit);
        longint l;
        l = limit;
        return longint'(rand_below(int'(2 * l))) - l / 2;
    endfunction

    // Within 32 pixels of the center
    function automatic coord_t near_coord(input longint center);
        return coord_t'(center + longint'(rand_below(64 << `BBOX_RADIX)) - (32 << `BBOX_RADIX));
    endfunction

    task automatic new_triangle();
        coord_t tmp;
        longint cx;
        longint cy;
        if (pair_pending) begin
            // Same triangle again with v1 and v2 swapped, so the winding flips
            tmp  = v1_x;
            v1_x = v2_x;
            v2_x = tmp;
            tmp  = v1_y;
            v1_y = v2_y;
            v2_y = tmp;
            pair_pending = 1'b0;
        end else begin
            if (rand_below(2) == 0) begin
                v0_x = span_coord(screen_w);
                v0_y = span_coord(screen_h);
                v1_x = span_coord(screen_w);
                v1_y = span_coord(screen_h);
                v2_x = span_coord(screen_w);
                v2_y = span_coord(screen_h);
            end else begin
                cx = center_coord(screen_w);
                cy = center_coord(screen_h);
                v0_x = near_coord(cx);
                v0_y = near_coord(cy);
                v1_x = near_coord(cx);
                v1_y = near_coord(cy);
                v2_x = near_coord(cx);
                v2_y = near_coord(cy);
            end
            pair_pending = 1'b1;
        end
        tri_valid = (rand_below(8) != 0);
        subsample = sample_codes[rand_below(5)];
    endtask

    task automatic compare_value(input string name, input longint exp, input longint got);
        checks++;
        assert (exp == got) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, exp, got);
        end
    endtask

    // Box corners must sit on the sample grid of their own triangle
    task automatic check_on_grid(input string name, input coord_t value, input int keep);
        longint low;
        longint frac;
        low  = (longint'(1) << (`BBOX_RADIX - keep)) - 1;
        frac = longint'(value) & low;
        checks++;
        assert (frac == 0) else begin
            errors++;
            $display("[FAIL] t=%0t %s fraction below %0d kept bits expected=0 actual=%0h",
                     $time, name, keep, frac);
        end
    endtask

    task automatic compare_outputs();
        logic [240:0] now_out;
        now_out = {out_v0_x, out_v0_y, out_v1_x, out_v1_y, out_v2_x, out_v2_y,
                   box_ll_x, box_ll_y, box_ur_x, box_ur_y, box_valid};
        compare_value("out_v0_x", longint'(pipe_v[2][0]), longint'(out_v0_x));
        compare_value("out_v0_y", longint'(pipe_v[2][1]), longint'(out_v0_y));
        compare_value("out_v1_x", longint'(pipe_v[2][2]), longint'(out_v1_x));
        compare_value("out_v1_y", longint'(pipe_v[2][3]), longint'(out_v1_y));
        compare_value("out_v2_x", longint'(pipe_v[2][4]), longint'(out_v2_x));
        compare_value("out_v2_y", longint'(pipe_v[2][5]), longint'(out_v2_y));
        compare_value("box_ll_x", longint'(pipe_box[2][0]), longint'(box_ll_x));
        compare_value("box_ll_y", longint'(pipe_box[2][1]), longint'(box_ll_y));
        compare_value("box_ur_x", longint'(pipe_box[2][2]), longint'(box_ur_x));
        compare_value("box_ur_y", longint'(pipe_box[2][3]), longint'(box_ur_y));
        compare_value("box_valid", longint'(pipe_valid[2]), longint'(box_valid));
        check_on_grid("box_ll_x", box_ll_x, pipe_keep[2]);
        check_on_grid("box_ll_y", box_ll_y, pipe_keep[2]);
        check_on_grid("box_ur_x", box_ur_x, pipe_keep[2]);
        check_on_grid("box_ur_y", box_ur_y, pipe_keep[2]);
        // A halted edge must leave every output as it was
        if (held_edge) begin
            checks++;
            assert (now_out == last_out) else begin
                errors++;
                $display("[FAIL] t=%0t held outputs expected=%h actual=%h",
                         $time, last_out, now_out);
            end
        end
        last_out = now_out;
    endtask

    // Model and handshake bookkeeping on the same edge the DUT samples
    always @(posedge clk) begin
        model_clock();
        taken     = rst_n && !halt;
        held_edge = rst_n && halt;
        if (taken) begin
            sent++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLE) begin
            $display("Timeout: run still going after %0d cycles, %0d triangles taken",
                     cycles, sent);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed = 32'h1011e7a7;
        errors = 0;
        checks = 0;
        sent = 0;
        cycles = 0;
        taken = 1'b0;
        held_edge = 1'b0;
        pair_pending = 1'b0;
        last_out = '0;
        rst_n = 1'b0;
        halt = 1'b0;
        tri_valid = 1'b0;
        subsample = 4'b1000;
        v0_x = '0;
        v0_y = '0;
        v1_x = '0;
        v1_y = '0;
        v2_x = '0;
        v2_y = '0;
        // Whole pixel screen, so clamped corners stay on every grid
        screen_w = coord_t'(longint'(256 + rand_below(769)) << `BBOX_RADIX);
        screen_h = coord_t'(longint'(256 + rand_below(513)) << `BBOX_RADIX);
        model_reset();
        culled = 0;
        rejected = 0;

        // Four rising edges in reset, box_valid checked low throughout
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            compare_outputs();
        end
        rst_n = 1'b1;
        new_triangle();
        halt = (rand_below(4) == 0);

        while (sent < NUM_TRI) begin
            @(negedge clk);
            compare_outputs();
            // Hold the triangle until an edge with halt low takes it
            if (taken && sent < NUM_TRI) begin
                new_triangle();
            end
            halt = (rand_below(4) == 0);
        end

        // Drain the pipe with bubbles
        tri_valid = 1'b0;
        halt = 1'b0;
        repeat (`BBOX_DEPTH + 1) begin
            @(negedge clk);
            compare_outputs();
        end

        $display("Summary: %0d errors in %0d checks, %0d triangles, %0d rejected, %0d culled",
                 errors, checks, sent, rejected, culled);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+rtl
+incdir+testbench
rtl/geometry_pkg.sv
rtl/sampling_pkg.sv
rtl/tri_input_stage.sv
rtl/axis_bound_lane.sv
rtl/cull_output_stage.sv
rtl/bbox_top.sv
testbench/bbox_tb.sv

/* Makefile */
TOP := bbox_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
